// File: compile.f
+incdir+design
+incdir+dv
design/exe_pkg.sv
design/exe_stage_reg.sv
design/exe_alu.sv
design/exe_hilo_unit.sv
design/exe_mem_access.sv
design/exe_stage.sv
dv/exe_stage_tb.sv

// File: dv/exe_ref_model.svh
`ifndef EXE_REF_MODEL_SVH
`define EXE_REF_MODEL_SVH

// expected behaviour of one instruction under the ISA rules

function automatic logic is_load_op(input exe_pkg::op_t op);
    case (op)
        `EXE_OP_LB, `EXE_OP_LBU, `EXE_OP_LH, `EXE_OP_LHU, `EXE_OP_LW: is_load_op = 1'b1;
        default: is_load_op = 1'b0;
    endcase
endfunction

function automatic logic is_mem_op(input exe_pkg::op_t op);
    is_mem_op = is_load_op(op) || (op == `EXE_OP_SB) || (op == `EXE_OP_SH) ||
                (op == `EXE_OP_SW);
endfunction

function automatic exe_pkg::word_t expected_result(input exe_pkg::op_t op,
                                                   input exe_pkg::word_t pc,
                                                   input exe_pkg::word_t a,
                                                   input exe_pkg::word_t b,
                                                   input exe_pkg::word_t hi,
                                                   input exe_pkg::word_t lo);
    case (op)
        `EXE_OP_ADD, `EXE_OP_ADDU: expected_result = a + b;
        `EXE_OP_SUB, `EXE_OP_SUBU: expected_result = a - b;
        `EXE_OP_SLT:  expected_result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        `EXE_OP_SLTU: expected_result = (a < b) ? 32'd1 : 32'd0;
        `EXE_OP_MOV:  expected_result = a;
        `EXE_OP_AND:  expected_result = a & b;
        `EXE_OP_OR:   expected_result = a | b;
        `EXE_OP_XOR:  expected_result = a ^ b;
        `EXE_OP_NOR:  expected_result = ~(a | b);
        `EXE_OP_SLL:  expected_result = a << b[4:0];
        `EXE_OP_SRL:  expected_result = a >> b[4:0];
        `EXE_OP_SRA:  expected_result = $signed(a) >>> b[4:0];
        `EXE_OP_LINK: expected_result = pc + `EXE_LINK_OFFSET;
        `EXE_OP_MFHI: expected_result = hi;
        `EXE_OP_MFLO: expected_result = lo;
        default:      expected_result = '0;
    endcase
endfunction

function automatic exe_pkg::exc_t raised_exc(input exe_pkg::op_t op,
                                             input exe_pkg::exc_t in_exc,
                                             input exe_pkg::word_t a,
                                             input exe_pkg::word_t b);
    exe_pkg::exc_t  exc;
    exe_pkg::word_t addr;
    logic [32:0]    wide;
    exc      = '0;
    exc[2:0] = in_exc[2:0];
    addr     = a + b;
    // sign-extended sum disagrees in its top two bits on overflow
    wide = (op == `EXE_OP_SUB) ? {a[31], a} - {b[31], b} : {a[31], a} + {b[31], b};
    exc[`EXE_EXC_OV] = ((op == `EXE_OP_ADD) || (op == `EXE_OP_SUB)) && (wide[32] != wide[31]);
    case (op)
        `EXE_OP_LW:              exc[`EXE_EXC_ADEL] = (addr[1:0] != 2'b00);
        `EXE_OP_LH, `EXE_OP_LHU: exc[`EXE_EXC_ADEL] = addr[0];
        `EXE_OP_SW:              exc[`EXE_EXC_ADES] = (addr[1:0] != 2'b00);
        `EXE_OP_SH:              exc[`EXE_EXC_ADES] = addr[0];
        default: begin
        end
    endcase
    raised_exc = exc;
endfunction

function automatic exe_pkg::byte_en_t lane_enables(input exe_pkg::op_t op,
                                                   input exe_pkg::word_t addr);
    case (op)
        `EXE_OP_SW: lane_enables = 4'b1111;
        `EXE_OP_SH: lane_enables = addr[1] ? 4'b1100 : 4'b0011;
        `EXE_OP_SB: lane_enables = 4'b0001 << addr[1:0];
        default:    lane_enables = 4'b0000;
    endcase
endfunction

function automatic exe_pkg::word_t replicated_wdata(input exe_pkg::op_t op,
                                                    input exe_pkg::word_t d);
    case (op)
        `EXE_OP_SW: replicated_wdata = d;
        `EXE_OP_SH: replicated_wdata = {d[15:0], d[15:0]};
        `EXE_OP_SB: replicated_wdata = {d[7:0], d[7:0], d[7:0], d[7:0]};
        default:    replicated_wdata = '0;
    endcase
endfunction

function automatic exe_pkg::byte_sel_t load_byte_sel(input exe_pkg::op_t op,
                                                     input exe_pkg::word_t addr);
    case (op)
        `EXE_OP_LB, `EXE_OP_LBU, `EXE_OP_LH, `EXE_OP_LHU: load_byte_sel = addr[1:0];
        default: load_byte_sel = '0;
    endcase
endfunction

// new {hi, lo} after a committed instruction
function automatic logic [63:0] next_hilo(input exe_pkg::op_t op, input exe_pkg::word_t a,
                                          input exe_pkg::word_t b, input exe_pkg::word_t hi,
                                          input exe_pkg::word_t lo);
    case (op)
        `EXE_OP_MULT:  next_hilo = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        `EXE_OP_MULTU: next_hilo = {32'd0, a} * {32'd0, b};
        `EXE_OP_MTHI:  next_hilo = {a, lo};
        `EXE_OP_MTLO:  next_hilo = {hi, a};
        default:       next_hilo = {hi, lo};
    endcase
endfunction

`endif

// File: dv/exe_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "exe_config.svh"

module exe_stage_tb;

    localparam int LIMIT = 200;

    logic                clock;
    logic                reset;
    logic                in_valid_i;
    logic                in_ready_o;
    exe_pkg::op_t        in_op_i;
    exe_pkg::reg_tag_t   in_dest_i;
    exe_pkg::word_t      in_pc_i;
    exe_pkg::exc_t       in_exc_i;
    exe_pkg::word_t      in_src1_i;
    exe_pkg::word_t      in_src2_i;
    exe_pkg::word_t      in_src3_i;
    logic                out_valid_o;
    logic                out_ready_i;
    exe_pkg::op_t        out_op_o;
    exe_pkg::reg_tag_t   out_dest_o;
    exe_pkg::word_t      out_pc_o;
    exe_pkg::word_t      out_result_o;
    exe_pkg::exc_t       out_exc_o;
    exe_pkg::word_t      out_bad_addr_o;
    logic                out_is_load_o;
    exe_pkg::byte_sel_t  out_load_sel_o;
    logic                dmem_en_o;
    exe_pkg::byte_en_t   dmem_wen_o;
    exe_pkg::word_t      dmem_addr_o;
    exe_pkg::word_t      dmem_wdata_o;

    // accepted instructions in order of arrival
    exe_pkg::op_t        q_op[$];
    exe_pkg::reg_tag_t   q_dest[$];
    exe_pkg::word_t      q_pc[$];
    exe_pkg::exc_t       q_exc[$];
    exe_pkg::word_t      q_s1[$];
    exe_pkg::word_t      q_s2[$];
    exe_pkg::word_t      q_s3[$];
    exe_pkg::word_t      model_hi;
    exe_pkg::word_t      model_lo;
    logic                stall_on;
    int                  checks;
    int                  errors;
    int                  seed;

    `include "exe_ref_model.svh"

    exe_stage UUT (.*);

    initial clock = 1'b0;
    always #50 clock = ~clock;

    always @(posedge clock) begin
        #1;
        out_ready_i = stall_on ? (($urandom % 3) != 0) : 1'b1;
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("timeout: %s", why);
        $display("Test failures found");
        $finish;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        $display("test %s: %s with %0d errors", name,
                 (errors == errors_before) ? "passed" : "failed", errors - errors_before);
    endtask

    function automatic exe_pkg::word_t align_mask(input exe_pkg::op_t op);
        case (op)
            `EXE_OP_LW, `EXE_OP_SW:              align_mask = 32'd3;
            `EXE_OP_LH, `EXE_OP_LHU, `EXE_OP_SH: align_mask = 32'd1;
            default:                             align_mask = 32'd0;
        endcase
    endfunction

    // called just after a rising edge, returns just after the accepting edge
    task automatic send(input exe_pkg::op_t op, input exe_pkg::word_t s1,
                        input exe_pkg::word_t s2, input exe_pkg::word_t s3,
                        input exe_pkg::exc_t exc);
        int waited;
        waited     = 0;
        in_valid_i = 1'b1;
        in_op_i    = op;
        in_src1_i  = s1;
        in_src2_i  = s2;
        in_src3_i  = s3;
        in_exc_i   = exc;
        in_pc_i    = $urandom & 32'hffff_fffc;
        in_dest_i  = $urandom;
        @(negedge clock);
        while (!in_ready_o && waited < LIMIT) begin
            waited++;
            @(negedge clock);
        end
        if (!in_ready_o) begin
            abort_run("the stage never accepted an instruction");
        end else begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic drain();
        int waited;
        waited     = 0;
        in_valid_i = 1'b0;
        while ((q_op.size() != 0 || out_valid_o) && waited < LIMIT) begin
            waited++;
            @(negedge clock);
        end
        if (q_op.size() != 0 || out_valid_o) begin
            abort_run("instructions stayed stuck in the stage");
        end else begin
            @(posedge clock);
            #1;
        end
    endtask

    // sampled at the falling edge where outputs are stable before the handover edge
    always @(negedge clock) begin : compare
        exe_pkg::exc_t  exp_exc;
        exe_pkg::word_t addr;
        logic [63:0]    hilo;
        logic           full;
        if (!reset) begin
            full = (q_op.size() != 0);
            check("out_valid_o", out_valid_o, full);
            check("in_ready_o", in_ready_o, !full || out_ready_i);
            if (!full) begin
                check("dmem_en_o while empty", dmem_en_o, 1'b0);
            end else begin
                addr    = q_s1[0] + q_s2[0];
                exp_exc = raised_exc(q_op[0], q_exc[0], q_s1[0], q_s2[0]);
                check("out_op_o", out_op_o, q_op[0]);
                check("out_dest_o", out_dest_o, q_dest[0]);
                check("out_pc_o", out_pc_o, q_pc[0]);
                check("out_result_o", out_result_o,
                      expected_result(q_op[0], q_pc[0], q_s1[0], q_s2[0], model_hi, model_lo));
                check("out_exc_o", out_exc_o, exp_exc);
                check("out_bad_addr_o", out_bad_addr_o,
                      (exp_exc[`EXE_EXC_ADEL] || exp_exc[`EXE_EXC_ADES]) ? addr : 32'd0);
                check("out_is_load_o", out_is_load_o, is_load_op(q_op[0]));
                check("out_load_sel_o", out_load_sel_o, load_byte_sel(q_op[0], addr));
                check("dmem_en_o", dmem_en_o,
                      out_ready_i && is_mem_op(q_op[0]) && (exp_exc == '0));
                if (is_mem_op(q_op[0])) begin
                    check("dmem_addr_o", dmem_addr_o, addr);
                    check("dmem_wen_o", dmem_wen_o, lane_enables(q_op[0], addr));
                    check("dmem_wdata_o", dmem_wdata_o, replicated_wdata(q_op[0], q_s3[0]));
                end
                if (out_ready_i) begin
                    if (exp_exc == '0) begin
                        hilo     = next_hilo(q_op[0], q_s1[0], q_s2[0], model_hi, model_lo);
                        model_hi = hilo[63:32];
                        model_lo = hilo[31:0];
                    end
                    void'(q_op.pop_front());
                    void'(q_dest.pop_front());
                    void'(q_pc.pop_front());
                    void'(q_exc.pop_front());
                    void'(q_s1.pop_front());
                    void'(q_s2.pop_front());
                    void'(q_s3.pop_front());
                end
            end
            if (in_valid_i && in_ready_o) begin
                q_op.push_back(in_op_i);
                q_dest.push_back(in_dest_i);
                q_pc.push_back(in_pc_i);
                q_exc.push_back(in_exc_i);
                q_s1.push_back(in_src1_i);
                q_s2.push_back(in_src2_i);
                q_s3.push_back(in_src3_i);
            end
        end
    end

    initial begin : run
        int             start;
        int             i;
        exe_pkg::op_t   op;
        exe_pkg::word_t a;
        exe_pkg::word_t b;
        seed        = $urandom(72304);
        reset       = 1'b1;
        in_valid_i  = 1'b0;
        in_op_i     = '0;
        in_dest_i   = '0;
        in_pc_i     = '0;
        in_exc_i    = '0;
        in_src1_i   = '0;
        in_src2_i   = '0;
        in_src3_i   = '0;
        out_ready_i = 1'b1;
        stall_on    = 1'b0;
        checks      = 0;
        errors      = 0;
        model_hi    = '0;
        model_lo    = '0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;

        start = errors;
        @(negedge clock);
        check("out_valid_o after reset", out_valid_o, 1'b0);
        check("dmem_en_o after reset", dmem_en_o, 1'b0);
        check("in_ready_o after reset", in_ready_o, 1'b1);
        @(posedge clock);
        #1;
        finish_test("reset", start);

        start = errors;
        for (i = 0; i < 300; i++) begin
            op = `EXE_OP_ADD + ($urandom % (`EXE_OP_LINK - `EXE_OP_ADD + 1));
            send(op, $urandom, $urandom, $urandom, '0);
        end
        drain();
        finish_test("alu", start);

        // occasional upstream exception bits must leave hi/lo alone
        start = errors;
        for (i = 0; i < 40; i++) begin
            op = (i % 2) ? `EXE_OP_MULTU : `EXE_OP_MULT;
            send(op, $urandom, $urandom, '0, (i % 5 == 4) ? 6'b000010 : 6'b000000);
            send(`EXE_OP_MFHI, '0, '0, '0, '0);
            send(`EXE_OP_MFLO, '0, '0, '0, '0);
            send(`EXE_OP_MTHI, $urandom, '0, '0, (i % 7 == 3) ? 6'b000001 : 6'b000000);
            send(`EXE_OP_MFHI, '0, '0, '0, '0);
            send(`EXE_OP_MTLO, $urandom, '0, '0, (i % 6 == 2) ? 6'b000100 : 6'b000000);
            send(`EXE_OP_MFLO, '0, '0, '0, '0);
        end
        drain();
        finish_test("hilo", start);

        start = errors;
        for (i = 0; i < 200; i++) begin
            op = `EXE_OP_LB + ($urandom % (`EXE_OP_SW - `EXE_OP_LB + 1));
            a  = $urandom;
            b  = $urandom;
            b  = b - ((a + b) & align_mask(op));
            send(op, a, b, $urandom, '0);
        end
        drain();
        finish_test("load_store", start);

        start = errors;
        for (i = 0; i < 200; i++) begin
            op = `EXE_OP_LB + ($urandom % (`EXE_OP_SW - `EXE_OP_LB + 1));
            a  = $urandom;
            b  = $urandom;
            if (align_mask(op) != 0) begin
                b = b - ((a + b) & align_mask(op)) + 1 + ($urandom % align_mask(op));
                send(op, a, b, $urandom, '0);
            end
        end
        drain();
        finish_test("misaligned", start);

        start    = errors;
        stall_on = 1'b1;
        for (i = 0; i < 600; i++) begin
            op = `EXE_OP_ADD + ($urandom % (`EXE_OP_SW - `EXE_OP_ADD + 1));
            send(op, $urandom, $urandom, $urandom, (($urandom % 8) == 0) ? ($urandom % 8) : 0);
        end
        drain();
        stall_on = 1'b0;
        finish_test("back_pressure", start);

        $display("checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/exe_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "exe_config.svh"

module exe_stage (
    input  wire                    clock,
    input  wire                    reset,

    input  wire                    in_valid_i,
    output logic                   in_ready_o,
    input  wire exe_pkg::op_t      in_op_i,
    input  wire exe_pkg::reg_tag_t in_dest_i,
    input  wire exe_pkg::word_t    in_pc_i,
    input  wire exe_pkg::exc_t     in_exc_i,
    input  wire exe_pkg::word_t    in_src1_i,
    input  wire exe_pkg::word_t    in_src2_i,
    input  wire exe_pkg::word_t    in_src3_i,

    output logic                   out_valid_o,
    input  wire                    out_ready_i,
    output exe_pkg::op_t           out_op_o,
    output exe_pkg::reg_tag_t      out_dest_o,
    output exe_pkg::word_t         out_pc_o,
    output exe_pkg::word_t         out_result_o,
    output exe_pkg::exc_t          out_exc_o,
    output exe_pkg::word_t         out_bad_addr_o,
    output logic                   out_is_load_o,
    output exe_pkg::byte_sel_t     out_load_sel_o,

    output logic                   dmem_en_o,
    output exe_pkg::byte_en_t      dmem_wen_o,
    output exe_pkg::word_t         dmem_addr_o,
    output exe_pkg::word_t         dmem_wdata_o
);

    logic              held_valid;
    exe_pkg::op_t      held_op;
    exe_pkg::exc_t     held_exc;
    exe_pkg::word_t    held_src1;
    exe_pkg::word_t    held_src2;
    exe_pkg::word_t    held_src3;
    logic              leave;
    logic              cancel;
    exe_pkg::word_t    alu_result;
    exe_pkg::word_t    addr;
    logic              overflow;
    exe_pkg::word_t    hilo_read;
    logic              adel;
    logic              ades;
    logic              is_hilo_read;
    logic              is_mem;
    exe_pkg::exc_t     exc;

    assign out_valid_o = held_valid;
    assign leave       = out_valid_o && out_ready_i;

    exe_stage_reg u_stage_reg (
        .clock      (clock),
        .reset      (reset),
        .in_valid_i (in_valid_i),
        .in_op_i    (in_op_i),
        .in_dest_i  (in_dest_i),
        .in_pc_i    (in_pc_i),
        .in_exc_i   (in_exc_i),
        .in_src1_i  (in_src1_i),
        .in_src2_i  (in_src2_i),
        .in_src3_i  (in_src3_i),
        .leave_i    (leave),
        .in_ready_o (in_ready_o),
        .valid_o    (held_valid),
        .op_o       (held_op),
        .dest_o     (out_dest_o),
        .pc_o       (out_pc_o),
        .exc_o      (held_exc),
        .src1_o     (held_src1),
        .src2_o     (held_src2),
        .src3_o     (held_src3)
    );

    exe_alu u_alu (
        .op_i       (held_op),
        .pc_i       (out_pc_o),
        .src1_i     (held_src1),
        .src2_i     (held_src2),
        .result_o   (alu_result),
        .addr_o     (addr),
        .overflow_o (overflow)
    );

    exe_hilo_unit u_hilo (
        .clock    (clock),
        .reset    (reset),
        .op_i     (held_op),
        .src1_i   (held_src1),
        .src2_i   (held_src2),
        .commit_i (leave),
        .cancel_i (cancel),
        .read_o   (hilo_read)
    );

    exe_mem_access u_mem_access (
        .op_i         (held_op),
        .addr_i       (addr),
        .src3_i       (held_src3),
        .valid_i      (held_valid),
        .commit_i     (leave),
        .cancel_i     (cancel),
        .adel_o       (adel),
        .ades_o       (ades),
        .is_load_o    (out_is_load_o),
        .load_sel_o   (out_load_sel_o),
        .dmem_en_o    (dmem_en_o),
        .dmem_wen_o   (dmem_wen_o),
        .dmem_wdata_o (dmem_wdata_o)
    );

    // upstream bits pass through, address and overflow bits are new
    always_comb begin
        exc                = '0;
        exc[2:0]           = held_exc[2:0];
        exc[`EXE_EXC_ADEL] = adel;
        exc[`EXE_EXC_ADES] = ades;
        exc[`EXE_EXC_OV]   = overflow;
    end

    assign cancel    = held_valid && (|exc);
    assign out_exc_o = exc;

    assign is_hilo_read = (held_op == `EXE_OP_MFHI) || (held_op == `EXE_OP_MFLO);
    assign is_mem       = out_is_load_o || (held_op == `EXE_OP_SB) ||
                          (held_op == `EXE_OP_SH) || (held_op == `EXE_OP_SW);

    assign out_result_o = is_hilo_read ? hilo_read :
                          is_mem       ? '0 : alu_result;

    assign out_op_o       = held_op;
    assign out_bad_addr_o = (adel || ades) ? addr : '0;
    assign dmem_addr_o    = addr;

endmodule

`default_nettype wire

// File: design/exe_mem_access.sv
`timescale 1ns/10ps
`default_nettype none

`include "exe_config.svh"

module exe_mem_access (
    input  wire exe_pkg::op_t   op_i,
    input  wire exe_pkg::word_t addr_i,
    input  wire exe_pkg::word_t src3_i,
    input  wire                 valid_i,
    input  wire                 commit_i,
    input  wire                 cancel_i,
    output logic                adel_o,
    output logic                ades_o,
    output logic                is_load_o,
    output exe_pkg::byte_sel_t  load_sel_o,
    output logic                dmem_en_o,
    output exe_pkg::byte_en_t   dmem_wen_o,
    output exe_pkg::word_t      dmem_wdata_o
);

    logic               op_lw;
    logic               op_half_load;
    logic               op_byte_load;
    logic               op_sw;
    logic               op_sh;
    logic               op_sb;
    logic               is_store;
    exe_pkg::byte_sel_t offset;

    assign op_lw        = (op_i == `EXE_OP_LW);
    assign op_half_load = (op_i == `EXE_OP_LH) || (op_i == `EXE_OP_LHU);
    assign op_byte_load = (op_i == `EXE_OP_LB) || (op_i == `EXE_OP_LBU);
    assign op_sw        = (op_i == `EXE_OP_SW);
    assign op_sh        = (op_i == `EXE_OP_SH);
    assign op_sb        = (op_i == `EXE_OP_SB);

    assign is_load_o = op_lw || op_half_load || op_byte_load;
    assign is_store  = op_sw || op_sh || op_sb;
    assign offset    = addr_i[1:0];

    // word access needs offset 0, halfword needs an even offset
    assign adel_o = valid_i && ((op_lw && (offset != 2'b00)) ||
                                (op_half_load && offset[0]));
    assign ades_o = valid_i && ((op_sw && (offset != 2'b00)) ||
                                (op_sh && offset[0]));

    // memory stage picks the lane for sub-word loads
    assign load_sel_o = (op_half_load || op_byte_load) ? offset : '0;

    always_comb begin
        dmem_wen_o = '0;
        if (op_sw) begin
            dmem_wen_o = '1;
        end else if (op_sh) begin
            dmem_wen_o = offset[1] ? 4'b1100 : 4'b0011;
        end else if (op_sb) begin
            dmem_wen_o = 4'b0001 << offset;
        end
    end

    // replicate so the enabled lanes carry the data
    always_comb begin
        if (op_sw) begin
            dmem_wdata_o = src3_i;
        end else if (op_sh) begin
            dmem_wdata_o = {2{src3_i[15:0]}};
        end else if (op_sb) begin
            dmem_wdata_o = {4{src3_i[7:0]}};
        end else begin
            dmem_wdata_o = '0;
        end
    end

    // request only in the handover cycle, never for a cancelled instruction
    assign dmem_en_o = commit_i && (is_load_o || is_store) && !cancel_i;

endmodule

`default_nettype wire

// File: design/exe_hilo_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "exe_config.svh"

module exe_hilo_unit (
    input  wire                 clock,
    input  wire                 reset,
    input  wire exe_pkg::op_t   op_i,
    input  wire exe_pkg::word_t src1_i,
    input  wire exe_pkg::word_t src2_i,
    input  wire                 commit_i,
    input  wire                 cancel_i,
    output exe_pkg::word_t      read_o
);

    localparam int W = `EXE_WORD_W;

    logic                   is_mult;
    logic signed [W:0]      mul_a;
    logic signed [W:0]      mul_b;
    logic signed [2*W+1:0]  prod_wide;
    logic [2*W-1:0]         product;
    exe_pkg::word_t         hi_q;
    exe_pkg::word_t         lo_q;

    assign is_mult = (op_i == `EXE_OP_MULT);

    // extra top bit is the sign for mult, zero for multu
    assign mul_a     = {is_mult && src1_i[W-1], src1_i};
    assign mul_b     = {is_mult && src2_i[W-1], src2_i};
    assign prod_wide = mul_a * mul_b;
    assign product   = prod_wide[2*W-1:0];

    // update only when the instruction leaves without an exception
    always_ff @(posedge clock) begin
        if (reset) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (commit_i && !cancel_i) begin
            case (op_i)
                `EXE_OP_MULT,
                `EXE_OP_MULTU: begin
                    hi_q <= product[2*W-1:W];
                    lo_q <= product[W-1:0];
                end
                `EXE_OP_MTHI: hi_q <= src1_i;
                `EXE_OP_MTLO: lo_q <= src1_i;
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        case (op_i)
            `EXE_OP_MFHI: read_o = hi_q;
            `EXE_OP_MFLO: read_o = lo_q;
            default:      read_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/exe_alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "exe_config.svh"

module exe_alu (
    input  wire exe_pkg::op_t   op_i,
    input  wire exe_pkg::word_t pc_i,
    input  wire exe_pkg::word_t src1_i,
    input  wire exe_pkg::word_t src2_i,
    output exe_pkg::word_t      result_o,
    output exe_pkg::word_t      addr_o,
    output logic                overflow_o
);

    localparam int W = `EXE_WORD_W;

    logic                    is_sub;
    logic                    is_link;
    exe_pkg::word_t          adder_a;
    exe_pkg::word_t          adder_b;
    logic [W:0]              sum_full;
    exe_pkg::word_t          sum;
    logic                    carry;
    logic                    lt_signed;
    logic                    lt_unsigned;
    logic [`EXE_SHAMT_W-1:0] shamt;
    logic                    shr_fill;
    logic [2*W-1:0]          shr_wide;
    exe_pkg::word_t          shl_res;
    exe_pkg::word_t          shr_res;

    assign is_sub  = (op_i == `EXE_OP_SUB)  || (op_i == `EXE_OP_SUBU) ||
                     (op_i == `EXE_OP_SLT)  || (op_i == `EXE_OP_SLTU);
    assign is_link = (op_i == `EXE_OP_LINK);

    // one adder for arithmetic, compares, link and address generation
    assign adder_a  = is_link ? pc_i : src1_i;
    assign adder_b  = is_link ? exe_pkg::word_t'(`EXE_LINK_OFFSET) :
                      is_sub  ? ~src2_i : src2_i;
    assign sum_full = {1'b0, adder_a} + {1'b0, adder_b} + {{W{1'b0}}, is_sub};
    assign sum      = sum_full[W-1:0];
    assign carry    = sum_full[W];
    assign addr_o   = sum;

    // a - b with a negative and b positive, or equal signs and negative difference
    assign lt_signed   = (src1_i[W-1] && !src2_i[W-1]) ||
                         (!(src1_i[W-1] ^ src2_i[W-1]) && sum[W-1]);
    // no borrow out means a >= b
    assign lt_unsigned = !carry;

    always_comb begin
        overflow_o = 1'b0;
        if (op_i == `EXE_OP_ADD) begin
            overflow_o = (src1_i[W-1] == src2_i[W-1]) && (sum[W-1] != src1_i[W-1]);
        end else if (op_i == `EXE_OP_SUB) begin
            overflow_o = (src1_i[W-1] != src2_i[W-1]) && (sum[W-1] != src1_i[W-1]);
        end
    end

    // shifts take the amount from the low bits of src2
    assign shamt    = src2_i[`EXE_SHAMT_W-1:0];
    assign shr_fill = (op_i == `EXE_OP_SRA) && src1_i[W-1];
    assign shr_wide = {{W{shr_fill}}, src1_i} >> shamt;
    assign shr_res  = shr_wide[W-1:0];
    assign shl_res  = src1_i << shamt;

    always_comb begin
        case (op_i)
            `EXE_OP_ADD,
            `EXE_OP_ADDU,
            `EXE_OP_SUB,
            `EXE_OP_SUBU,
            `EXE_OP_LINK: result_o = sum;
            `EXE_OP_SLT:  result_o = exe_pkg::word_t'(lt_signed);
            `EXE_OP_SLTU: result_o = exe_pkg::word_t'(lt_unsigned);
            `EXE_OP_MOV:  result_o = src1_i;
            `EXE_OP_AND:  result_o = src1_i & src2_i;
            `EXE_OP_OR:   result_o = src1_i | src2_i;
            `EXE_OP_XOR:  result_o = src1_i ^ src2_i;
            `EXE_OP_NOR:  result_o = ~(src1_i | src2_i);
            `EXE_OP_SLL:  result_o = shl_res;
            `EXE_OP_SRL,
            `EXE_OP_SRA:  result_o = shr_res;
            default:      result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/exe_stage_reg.sv
`timescale 1ns/10ps
`default_nettype none

module exe_stage_reg (
    input  wire                 clock,
    input  wire                 reset,

    input  wire                 in_valid_i,
    input  wire exe_pkg::op_t     in_op_i,
    input  wire exe_pkg::reg_tag_t in_dest_i,
    input  wire exe_pkg::word_t   in_pc_i,
    input  wire exe_pkg::exc_t    in_exc_i,
    input  wire exe_pkg::word_t   in_src1_i,
    input  wire exe_pkg::word_t   in_src2_i,
    input  wire exe_pkg::word_t   in_src3_i,

    input  wire                 leave_i,
    output logic                in_ready_o,

    output logic                valid_o,
    output exe_pkg::op_t        op_o,
    output exe_pkg::reg_tag_t   dest_o,
    output exe_pkg::word_t      pc_o,
    output exe_pkg::exc_t       exc_o,
    output exe_pkg::word_t      src1_o,
    output exe_pkg::word_t      src2_o,
    output exe_pkg::word_t      src3_o
);

    logic valid_q;

    // room when empty or the held item leaves this cycle
    assign in_ready_o = !valid_q || leave_i;
    assign valid_o    = valid_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    // instruction fields
    always_ff @(posedge clock) begin
        if (in_valid_i && in_ready_o) begin
            op_o   <= in_op_i;
            dest_o <= in_dest_i;
            pc_o   <= in_pc_i;
            exc_o  <= in_exc_i;
            src1_o <= in_src1_i;
            src2_o <= in_src2_i;
            src3_o <= in_src3_i;
        end
    end

endmodule

`default_nettype wire

// File: design/exe_pkg.sv
`default_nettype none

`include "exe_config.svh"

package exe_pkg;

    // data word, also used for addresses and hi/lo
    typedef logic [`EXE_WORD_W-1:0] word_t;

    typedef logic [`EXE_OP_W-1:0] op_t;

    // destination register tag
    typedef logic [`EXE_REG_W-1:0] reg_tag_t;

    // bits 2..0 from upstream, 5..3 raised in execute
    typedef logic [`EXE_EXC_W-1:0] exc_t;

    // bit n enables byte lane n
    typedef logic [`EXE_BE_W-1:0] byte_en_t;

    // byte offset within a word
    typedef logic [$clog2(`EXE_BE_W)-1:0] byte_sel_t;

endpackage

`default_nettype wire

// File: design/exe_config.svh
`ifndef EXE_CONFIG_SVH
`define EXE_CONFIG_SVH

// datapath widths
`define EXE_WORD_W      32
`define EXE_OP_W        8
`define EXE_REG_W       7
`define EXE_EXC_W       6
`define EXE_SHAMT_W     5
`define EXE_BE_W        4

// return address is two instructions past the branch
`define EXE_LINK_OFFSET 8

// opcodes
`define EXE_OP_ADD      8'h01
`define EXE_OP_ADDU     8'h02
`define EXE_OP_SUB      8'h03
`define EXE_OP_SUBU     8'h04
`define EXE_OP_SLT      8'h05
`define EXE_OP_SLTU     8'h06
`define EXE_OP_MOV      8'h07
`define EXE_OP_AND      8'h08
`define EXE_OP_OR       8'h09
`define EXE_OP_XOR      8'h0a
`define EXE_OP_NOR      8'h0b
`define EXE_OP_SLL      8'h0c
`define EXE_OP_SRL      8'h0d
`define EXE_OP_SRA      8'h0e
`define EXE_OP_LINK     8'h0f
`define EXE_OP_MULT     8'h10
`define EXE_OP_MULTU    8'h11
`define EXE_OP_MFHI     8'h12
`define EXE_OP_MFLO     8'h13
`define EXE_OP_MTHI     8'h14
`define EXE_OP_MTLO     8'h15
`define EXE_OP_LB       8'h16
`define EXE_OP_LBU      8'h17
`define EXE_OP_LH       8'h18
`define EXE_OP_LHU      8'h19
`define EXE_OP_LW       8'h1a
`define EXE_OP_SB       8'h1b
`define EXE_OP_SH       8'h1c
`define EXE_OP_SW       8'h1d

// exception vector bits raised in this stage
`define EXE_EXC_ADEL    5
`define EXE_EXC_ADES    4
`define EXE_EXC_OV      3

`endif
